// File: source/fft_pkg.sv
package fft_pkg;

	localparam int FFT_POINTS = 16;
	localparam int FFT_STAGES = 4;
	localparam int SAMPLE_W = 20;
	localparam int TWIDDLE_W = 18;
	localparam int TWIDDLE_FRAC = 16; // 1.0 is 2**16

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [TWIDDLE_W-1:0] twiddle_t;
	typedef logic [3:0] index_t;

	typedef enum logic [1:0]
	{
		stage_idle,
		stage_busy,
		stage_flush
	} stage_state_t;

	// W16^k = cos(2 pi k/16) - j sin(2 pi k/16)
	localparam twiddle_t twiddle_cos [0:7] = '{
		18'sd65536,
		18'sd60547,
		18'sd46341,
		18'sd25080,
		18'sd0,
		-18'sd25080,
		-18'sd46341,
		-18'sd60547
	};

	localparam twiddle_t twiddle_sin [0:7] = '{ // Already negated
		18'sd0,
		-18'sd25080,
		-18'sd46341,
		-18'sd60547,
		-18'sd65536,
		-18'sd60547,
		-18'sd46341,
		-18'sd25080
	};

endpackage : fft_pkg

// File: source/frame_bank.sv
`timescale 1ns/1ps

module frame_bank import fft_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic wr_en,
	input index_t wr_addr_a,
	input index_t wr_addr_b,
	input sample_t wr_real_a,
	input sample_t wr_imag_a,
	input sample_t wr_real_b,
	input sample_t wr_imag_b,
	input logic wr_done,
	input index_t rd_addr_a,
	input index_t rd_addr_b,
	input logic rd_release,
	output sample_t rd_real_a,
	output sample_t rd_imag_a,
	output sample_t rd_real_b,
	output sample_t rd_imag_b,
	output logic frame_ready,
	output logic wr_bank_full
);

	sample_t bank_real [0:1][0:FFT_POINTS-1];
	sample_t bank_imag [0:1][0:FFT_POINTS-1];
	logic wr_bank, rd_bank;
	logic [1:0] full;

	assign frame_ready = full[rd_bank];
	assign wr_bank_full = full[wr_bank];

	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			bank_real[wr_bank][wr_addr_b] <= wr_real_b;
			bank_imag[wr_bank][wr_addr_b] <= wr_imag_b;
			bank_real[wr_bank][wr_addr_a] <= wr_real_a; // Port a wins on a clash
			bank_imag[wr_bank][wr_addr_a] <= wr_imag_a;
		end
		rd_real_a <= bank_real[rd_bank][rd_addr_a];
		rd_imag_a <= bank_imag[rd_bank][rd_addr_a];
		rd_real_b <= bank_real[rd_bank][rd_addr_b];
		rd_imag_b <= bank_imag[rd_bank][rd_addr_b];
	end

	// Ping-pong pointers and full flags
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_bank <= 1'b0;
			rd_bank <= 1'b0;
			full <= '0;
		end
		else
		begin
			if (wr_done)
			begin
				full[wr_bank] <= 1'b1;
				wr_bank <= ~wr_bank;
			end
			if (rd_release)
			begin
				full[rd_bank] <= 1'b0;
				rd_bank <= ~rd_bank;
			end
		end
	end

endmodule : frame_bank

// File: source/butterfly.sv
`timescale 1ns/1ps

module butterfly import fft_pkg::*;
(
	input logic clk,
	input logic in_valid,
	input sample_t a_real,
	input sample_t a_imag,
	input sample_t b_real,
	input sample_t b_imag,
	input twiddle_t w_cos,
	input twiddle_t w_sin,
	output sample_t sum_real,
	output sample_t sum_imag,
	output sample_t diff_real,
	output sample_t diff_imag,
	output logic out_valid
);

	logic signed [SAMPLE_W+TWIDDLE_W:0] prod_real, prod_imag;
	logic signed [SAMPLE_W+1:0] t_real, t_imag;
	logic signed [SAMPLE_W+2:0] sum_r, sum_i, diff_r, diff_i;
	sample_t a_real_d, a_imag_d;
	logic mul_valid;

	always_comb
	begin
		prod_real = b_real * w_cos - b_imag * w_sin;
		prod_imag = b_real * w_sin + b_imag * w_cos;
		sum_r = a_real_d + t_real;
		sum_i = a_imag_d + t_imag;
		diff_r = a_real_d - t_real;
		diff_i = a_imag_d - t_imag;
	end

	always_ff @(posedge clk)
	begin
		mul_valid <= in_valid;
		a_real_d <= a_real;
		a_imag_d <= a_imag;
		t_real <= prod_real[TWIDDLE_FRAC +: SAMPLE_W+2]; // Truncate fraction
		t_imag <= prod_imag[TWIDDLE_FRAC +: SAMPLE_W+2];

		out_valid <= mul_valid;
		sum_real <= sum_r[SAMPLE_W:1]; // Halved
		sum_imag <= sum_i[SAMPLE_W:1];
		diff_real <= diff_r[SAMPLE_W:1];
		diff_imag <= diff_i[SAMPLE_W:1];
	end

endmodule : butterfly

// File: source/fft_stage.sv
`timescale 1ns/1ps

module fft_stage import fft_pkg::*;
#(
	parameter int STAGE_INDEX = 0
)
(
	input logic clk,
	input logic reset,
	input logic up_ready,
	input sample_t up_real_a,
	input sample_t up_imag_a,
	input sample_t up_real_b,
	input sample_t up_imag_b,
	output index_t up_addr_a,
	output index_t up_addr_b,
	output logic up_release,
	input index_t rd_addr_a,
	input index_t rd_addr_b,
	input logic rd_release,
	output sample_t rd_real_a,
	output sample_t rd_imag_a,
	output sample_t rd_real_b,
	output sample_t rd_imag_b,
	output logic frame_ready
);

	stage_state_t state;
	logic [2:0] bf_count;
	logic [2:0] tw_idx;
	logic [2:0] last_pipe;
	logic start, issue, wr_bank_full, wr_done;
	logic bf_valid, bf_out_valid;
	index_t pos;
	index_t addr_a_pipe [0:2];
	index_t addr_b_pipe [0:2];
	twiddle_t w_cos, w_sin;
	sample_t sum_real, sum_imag, diff_real, diff_imag;

	assign start = (state == stage_idle) && up_ready && !wr_bank_full;
	assign issue = start || (state == stage_busy);
	assign wr_done = bf_out_valid && last_pipe[2];
	assign up_release = wr_done;

	// Pair addresses and twiddle exponent for this stage's span
	always_comb
	begin
		pos = {1'b0, bf_count} & index_t'((1 << STAGE_INDEX) - 1);
		up_addr_a = index_t'(({1'b0, bf_count} >> STAGE_INDEX) << (STAGE_INDEX + 1)) | pos;
		up_addr_b = up_addr_a | index_t'(1 << STAGE_INDEX);
		tw_idx = 3'(pos << (FFT_STAGES - 1 - STAGE_INDEX));
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= stage_idle;
			bf_count <= '0;
			bf_valid <= 1'b0;
			last_pipe <= '0;
		end
		else
		begin
			bf_valid <= issue;
			last_pipe <= {last_pipe[1:0], issue && (bf_count == 3'd7)};
			if (issue)
				bf_count <= bf_count + 3'd1;
			case (state)
				stage_idle:
					if (start)
						state <= stage_busy;
				stage_busy:
					if (bf_count == 3'd7)
						state <= stage_flush;
				stage_flush:
					if (wr_done)
						state <= stage_idle;
				default:
					state <= stage_idle;
			endcase
		end
	end

	// Twiddle lines up with read data, addresses with butterfly output
	always_ff @(posedge clk)
	begin
		w_cos <= twiddle_cos[tw_idx];
		w_sin <= twiddle_sin[tw_idx];
		addr_a_pipe[0] <= up_addr_a;
		addr_b_pipe[0] <= up_addr_b;
		for (int i = 1; i < 3; i++)
		begin
			addr_a_pipe[i] <= addr_a_pipe[i-1];
			addr_b_pipe[i] <= addr_b_pipe[i-1];
		end
	end

	butterfly u_butterfly (
		.clk(clk),
		.in_valid(bf_valid),
		.a_real(up_real_a),
		.a_imag(up_imag_a),
		.b_real(up_real_b),
		.b_imag(up_imag_b),
		.w_cos(w_cos),
		.w_sin(w_sin),
		.sum_real(sum_real),
		.sum_imag(sum_imag),
		.diff_real(diff_real),
		.diff_imag(diff_imag),
		.out_valid(bf_out_valid)
	);

	frame_bank u_bank (
		.clk(clk),
		.reset(reset),
		.wr_en(bf_out_valid),
		.wr_addr_a(addr_a_pipe[2]),
		.wr_addr_b(addr_b_pipe[2]),
		.wr_real_a(sum_real),
		.wr_imag_a(sum_imag),
		.wr_real_b(diff_real),
		.wr_imag_b(diff_imag),
		.wr_done(wr_done),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.rd_release(rd_release),
		.rd_real_a(rd_real_a),
		.rd_imag_a(rd_imag_a),
		.rd_real_b(rd_real_b),
		.rd_imag_b(rd_imag_b),
		.frame_ready(frame_ready),
		.wr_bank_full(wr_bank_full)
	);

endmodule : fft_stage

// File: source/sample_loader.sv
`timescale 1ns/1ps

module sample_loader import fft_pkg::*;
(
	input logic clk,
	input logic reset,
	input sample_t realin,
	input sample_t imagin,
	input logic startin,
	input index_t rd_addr_a,
	input index_t rd_addr_b,
	input logic rd_release,
	output sample_t rd_real_a,
	output sample_t rd_imag_a,
	output sample_t rd_real_b,
	output sample_t rd_imag_b,
	output logic frame_ready
);

	index_t count, wr_addr;
	logic capture, wr_done, wr_bank_full;

	// startin is ignored while the target bank still holds a frame
	assign capture = (count != '0) || (startin && !wr_bank_full);
	assign wr_done = capture && (count == 4'd15);
	assign wr_addr = {count[0], count[1], count[2], count[3]}; // Bit reversed

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			count <= '0;
		else if (capture)
			count <= count + 4'd1;
	end

	frame_bank u_bank (
		.clk(clk),
		.reset(reset),
		.wr_en(capture),
		.wr_addr_a(wr_addr),
		.wr_addr_b(wr_addr), // Port b mirrors port a
		.wr_real_a(realin),
		.wr_imag_a(imagin),
		.wr_real_b(realin),
		.wr_imag_b(imagin),
		.wr_done(wr_done),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.rd_release(rd_release),
		.rd_real_a(rd_real_a),
		.rd_imag_a(rd_imag_a),
		.rd_real_b(rd_real_b),
		.rd_imag_b(rd_imag_b),
		.frame_ready(frame_ready),
		.wr_bank_full(wr_bank_full)
	);

endmodule : sample_loader

// File: source/spectrum_unloader.sv
`timescale 1ns/1ps

module spectrum_unloader import fft_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic up_ready,
	input sample_t up_real_a,
	input sample_t up_imag_a,
	output index_t up_addr_a,
	output logic up_release,
	output sample_t realout,
	output sample_t imagout,
	output logic startout
);

	index_t bin;
	logic reading;
	logic out_valid;

	// Once started, the bin counter runs through all 16 reads
	assign reading = (bin != '0) || up_ready;
	assign up_addr_a = bin;
	assign up_release = reading && (bin == 4'd15);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			bin <= '0;
			out_valid <= 1'b0;
			startout <= 1'b0;
		end
		else
		begin
			if (reading)
				bin <= bin + 4'd1;
			out_valid <= reading;
			startout <= reading && (bin == '0); // Bin 0 on the bus next cycle
		end
	end

	// Bank read data is already registered
	assign realout = out_valid ? up_real_a : '0;
	assign imagout = out_valid ? up_imag_a : '0;

endmodule : spectrum_unloader

// File: source/fft16.sv
`timescale 1ns/1ps

module fft16 import fft_pkg::*;
(
	input logic clk,
	input logic reset,
	input sample_t realin,
	input sample_t imagin,
	input logic startin,
	output sample_t realout,
	output sample_t imagout,
	output logic startout
);

	// Link k sits between the loader or stage k-1 and its reader
	sample_t link_real_a [0:FFT_STAGES];
	sample_t link_imag_a [0:FFT_STAGES];
	sample_t link_real_b [0:FFT_STAGES];
	sample_t link_imag_b [0:FFT_STAGES];
	index_t link_addr_a [0:FFT_STAGES];
	index_t link_addr_b [0:FFT_STAGES];
	logic link_ready [0:FFT_STAGES];
	logic link_release [0:FFT_STAGES];

	assign link_addr_b[FFT_STAGES] = '0; // Unloader reads port a only

	sample_loader u_loader (
		.clk(clk),
		.reset(reset),
		.realin(realin),
		.imagin(imagin),
		.startin(startin),
		.rd_addr_a(link_addr_a[0]),
		.rd_addr_b(link_addr_b[0]),
		.rd_release(link_release[0]),
		.rd_real_a(link_real_a[0]),
		.rd_imag_a(link_imag_a[0]),
		.rd_real_b(link_real_b[0]),
		.rd_imag_b(link_imag_b[0]),
		.frame_ready(link_ready[0])
	);

	genvar s;
	generate
		for (s = 0; s < FFT_STAGES; s++)
		begin : g_stage
			fft_stage #(
				.STAGE_INDEX(s)
			) u_stage (
				.clk(clk),
				.reset(reset),
				.up_ready(link_ready[s]),
				.up_real_a(link_real_a[s]),
				.up_imag_a(link_imag_a[s]),
				.up_real_b(link_real_b[s]),
				.up_imag_b(link_imag_b[s]),
				.up_addr_a(link_addr_a[s]),
				.up_addr_b(link_addr_b[s]),
				.up_release(link_release[s]),
				.rd_addr_a(link_addr_a[s+1]),
				.rd_addr_b(link_addr_b[s+1]),
				.rd_release(link_release[s+1]),
				.rd_real_a(link_real_a[s+1]),
				.rd_imag_a(link_imag_a[s+1]),
				.rd_real_b(link_real_b[s+1]),
				.rd_imag_b(link_imag_b[s+1]),
				.frame_ready(link_ready[s+1])
			);
		end
	endgenerate

	spectrum_unloader u_unloader (
		.clk(clk),
		.reset(reset),
		.up_ready(link_ready[FFT_STAGES]),
		.up_real_a(link_real_a[FFT_STAGES]),
		.up_imag_a(link_imag_a[FFT_STAGES]),
		.up_addr_a(link_addr_a[FFT_STAGES]),
		.up_release(link_release[FFT_STAGES]),
		.realout(realout),
		.imagout(imagout),
		.startout(startout)
	);

endmodule : fft16

// File: tb/fft_ref.svh
`ifndef FFT_REF_SVH
`define FFT_REF_SVH

localparam real REF_PI = 3.14159265358979323846;

// X[k] = sum x[n] (cos - j sin), then scaled by 1/16 like the four halving stages
function automatic real ref_bin_real(input int re [0:FFT_POINTS-1],
	input int im [0:FFT_POINTS-1], input int k);
	real acc;
	real ang;
	acc = 0.0;
	for (int n = 0; n < FFT_POINTS; n++)
	begin
		ang = 2.0 * REF_PI * real'((n * k) % FFT_POINTS) / real'(FFT_POINTS);
		acc = acc + real'(re[n]) * $cos(ang) + real'(im[n]) * $sin(ang);
	end
	return acc / real'(FFT_POINTS);
endfunction

function automatic real ref_bin_imag(input int re [0:FFT_POINTS-1],
	input int im [0:FFT_POINTS-1], input int k);
	real acc;
	real ang;
	acc = 0.0;
	for (int n = 0; n < FFT_POINTS; n++)
	begin
		ang = 2.0 * REF_PI * real'((n * k) % FFT_POINTS) / real'(FFT_POINTS);
		acc = acc + real'(im[n]) * $cos(ang) - real'(re[n]) * $sin(ang);
	end
	return acc / real'(FFT_POINTS);
endfunction

function automatic bit within_tol(input real expected, input int actual, input real tol);
	real diff;
	diff = real'(actual) - expected;
	return (diff <= tol) && (diff >= -tol);
endfunction

`endif

// File: tb/fft16_tb.sv
`timescale 1ns/1ps

module fft16_tb import fft_pkg::*; ();

	logic clk;
	logic reset;
	logic startin;
	sample_t realin;
	sample_t imagin;
	sample_t realout;
	sample_t imagout;
	logic startout;

	int frame_re [0:FFT_POINTS-1];
	int frame_im [0:FFT_POINTS-1];
	real exp_re_q [$];
	real exp_im_q [$];
	real tol_q [$];

	`include "fft_ref.svh"

	fft16 dut0 (
		.clk(clk),
		.reset(reset),
		.realin(realin),
		.imagin(imagin),
		.startin(startin),
		.realout(realout),
		.imagout(imagout),
		.startout(startout)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic value_error(input string name, input real expected, input int actual);
		fail_run($sformatf("Error at %0t: %s expected %0.3f, got %0d",
			$time, name, expected, actual));
	endtask

	function automatic int rand_component();
		return int'($urandom_range(262144)) - 131072; // Within +-2^17
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(negedge clk);
			startin = 1'b0;
			realin = '0;
			imagin = '0;
		end
	endtask

	// Loader counts samples 1 to 15 after startin
	task automatic send_frame();
		for (int i = 0; i < FFT_POINTS; i++)
		begin
			@(negedge clk);
			startin = (i == 0);
			realin = sample_t'(frame_re[i]);
			imagin = sample_t'(frame_im[i]);
		end
	endtask

	task automatic queue_exact(input int bin0, input int others);
		for (int k = 0; k < FFT_POINTS; k++)
		begin
			exp_re_q.push_back(real'((k == 0) ? bin0 : others));
			exp_im_q.push_back(0.0);
			tol_q.push_back(0.0);
		end
	endtask

	task automatic queue_reference();
		for (int k = 0; k < FFT_POINTS; k++)
		begin
			exp_re_q.push_back(ref_bin_real(frame_re, frame_im, k));
			exp_im_q.push_back(ref_bin_imag(frame_re, frame_im, k));
			tol_q.push_back(4.0);
		end
	endtask

	task automatic fill_random();
		for (int n = 0; n < FFT_POINTS; n++)
		begin
			frame_re[n] = rand_component();
			frame_im[n] = rand_component();
		end
	endtask

	task automatic wait_spectra(input int max_cycles);
		int cycles;
		cycles = 0;
		while (exp_re_q.size() != 0)
		begin
			@(negedge clk);
			cycles++;
			assert (cycles <= max_cycles)
			else
				fail_run("Timeout while waiting for startout and the spectrum bins");
		end
	endtask

	// One bin per cycle after startout
	initial
	begin
		int bins_left;
		real exp_re;
		real exp_im;
		real tol;
		bins_left = 0;
		forever
		begin
			@(negedge clk);
			if (startout)
			begin
				assert (bins_left == 0)
				else
					fail_run("startout came while a spectrum was still being output");
				assert (exp_re_q.size() != 0)
				else
					fail_run("startout came with no frame outstanding");
				bins_left = FFT_POINTS;
			end
			if (bins_left > 0)
			begin
				exp_re = exp_re_q.pop_front();
				exp_im = exp_im_q.pop_front();
				tol = tol_q.pop_front();
				assert (within_tol(exp_re, realout, tol))
				else
					value_error("realout", exp_re, realout);
				assert (within_tol(exp_im, imagout, tol))
				else
					value_error("imagout", exp_im, imagout);
				bins_left--;
			end
			else
			begin
				assert (realout == '0) else value_error("realout", 0.0, realout);
				assert (imagout == '0) else value_error("imagout", 0.0, imagout);
			end
		end
	end

	initial
	begin
		int k_val;
		int a_val;
		void'($urandom(86));
		reset = 1'b1;
		startin = 1'b0;
		realin = '0;
		imagin = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		idle_cycles(40); // Quiet outputs with no input

		// Impulse gives a flat spectrum
		k_val = int'($urandom_range(32767)) - 16384;
		frame_re = '{default: 0};
		frame_im = '{default: 0};
		frame_re[0] = 16 * k_val;
		queue_exact(k_val, k_val);
		send_frame();
		idle_cycles(1);
		wait_spectra(300);

		// Constant frame lands in bin 0 only
		a_val = 16 * (int'($urandom_range(16000)) - 8000);
		frame_re = '{default: a_val};
		frame_im = '{default: 0};
		queue_exact(a_val, 0);
		send_frame();
		idle_cycles(1);
		wait_spectra(300);

		for (int f = 0; f < 3; f++) // Back to back
		begin
			fill_random();
			queue_reference();
			send_frame();
		end
		idle_cycles(1);
		wait_spectra(500);

		for (int f = 0; f < 3; f++)
		begin
			fill_random();
			queue_reference();
			send_frame();
			idle_cycles(int'($urandom_range(24)));
		end
		idle_cycles(1);
		wait_spectra(500);

		idle_cycles(20);
		$display("NO ERRORS");
		$finish;
	end

endmodule : fft16_tb

// File: flist.f
+incdir+tb
source/fft_pkg.sv
source/frame_bank.sv
source/butterfly.sv
source/fft_stage.sv
source/sample_loader.sv
source/spectrum_unloader.sv
source/fft16.sv
tb/fft16_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module fft16_tb -o fft16_sim

# The testbench exits nonzero on failure, the log decides
./obj_dir/fft16_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi
echo "Simulation passed"
